// File: project.f
+incdir+source
source/pi1_bus_pkg.sv
source/mem_pkg.sv
source/pi1_upconverter.sv
source/pi1_arbiter.sv
source/pi1_sram.sv
source/pi1_subsystem_top.sv
tests/tb_pi1_subsystem.sv

// File: run_sim.sh
#!/bin/sh
# Builds the pi1 subsystem testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module tb_pi1_subsystem -f project.f \
	> build.log 2>&1 || { cat build.log; echo "Build failed."; exit 1; }

./obj_dir/Vtb_pi1_subsystem > sim.log 2>&1 || echo "=== FAIL ===" >> sim.log
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed."; exit 1; } || exit 0

// File: source/mem_pkg.sv
// On-chip RAM types
`include "pi1_config.svh"

package mem_pkg;

	// One RAM word.
	typedef logic [`PI1_WIDE_BITS-1:0] mem_word_t;

	// Byte enables, one per byte of a word.
	typedef logic [`PI1_WSEL_BITS-1:0] mem_be_t;

	// Word index into the RAM.
	typedef logic [`PI1_WADDR_BITS-1:0] mem_index_t;

endpackage

// File: source/pi1_arbiter.sv
// Two-port pi1 arbiter
`timescale 1ns/10ps

module pi1_arbiter (
	input  logic                    clk_i,
	input  logic                    reset_i,

	input  pi1_bus_pkg::pi1_wreq_t  a_req_i,
	output mem_pkg::mem_word_t      a_data_o,
	output logic                    a_rdy_o,

	input  pi1_bus_pkg::pi1_wreq_t  b_req_i,
	output mem_pkg::mem_word_t      b_data_o,
	output logic                    b_rdy_o,

	output pi1_bus_pkg::pi1_wreq_t  s_req_o,
	input  mem_pkg::mem_word_t      s_data_i,
	input  logic                    s_rdy_i
);

	logic a_want;
	logic b_want;
	logic a_win;
	logic b_win;
	logic a_load;
	logic b_load;

	logic prio_b_q; // Port B wins the next contested cycle.
	logic ret_a_q;  // The slave data in this cycle belongs to port A.
	logic ret_b_q;

	mem_pkg::mem_word_t a_data_q;
	mem_pkg::mem_word_t b_data_q;

	assign a_want = (a_req_i.op != pi1_bus_pkg::PI1_OP_NOP);
	assign b_want = (b_req_i.op != pi1_bus_pkg::PI1_OP_NOP);

	assign a_win = a_want && (!b_want || !prio_b_q);
	assign b_win = b_want && !a_win;

	assign s_req_o = b_win ? b_req_i : a_req_i;

	// An idle port simply sees the slave's ready.
	assign a_rdy_o = s_rdy_i && (a_win || !a_want);
	assign b_rdy_o = s_rdy_i && (b_win || !b_want);

	assign a_load = s_rdy_i && a_win && (a_req_i.op == pi1_bus_pkg::PI1_OP_READ
		|| a_req_i.op == pi1_bus_pkg::PI1_OP_SWAP);
	assign b_load = s_rdy_i && b_win && (b_req_i.op == pi1_bus_pkg::PI1_OP_READ
		|| b_req_i.op == pi1_bus_pkg::PI1_OP_SWAP);

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			prio_b_q <= 1'b0;
			ret_a_q  <= 1'b0;
			ret_b_q  <= 1'b0;
		end else begin
			if (s_rdy_i && a_want && b_want) begin
				prio_b_q <= a_win; // The winner yields next time.
			end
			ret_a_q <= a_load;
			ret_b_q <= b_load;
		end
	end

	// Each port keeps its own copy, since the slave data moves on with the other port's reads.
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			a_data_q <= '0;
			b_data_q <= '0;
		end else begin
			if (ret_a_q) begin
				a_data_q <= s_data_i;
			end
			if (ret_b_q) begin
				b_data_q <= s_data_i;
			end
		end
	end

	assign a_data_o = ret_a_q ? s_data_i : a_data_q;
	assign b_data_o = ret_b_q ? s_data_i : b_data_q;

	// Whenever the slave takes a request, exactly one port was accepted for it.
	a_one_accept : assert property (
		@(posedge clk_i) disable iff (reset_i)
		(s_rdy_i && s_req_o.op != pi1_bus_pkg::PI1_OP_NOP)
		|-> ((a_want && a_rdy_o) != (b_want && b_rdy_o))
	);

endmodule

// File: source/pi1_bus_pkg.sv
// pi1 bus operations and requests
`include "pi1_config.svh"

package pi1_bus_pkg;

	// Swap returns the old word and stores the new one.
	typedef enum logic [1:0] {
		PI1_OP_NOP   = 2'd0,
		PI1_OP_WRITE = 2'd1,
		PI1_OP_READ  = 2'd2,
		PI1_OP_SWAP  = 2'd3
	} pi1_op_t;

	// Request from the 32-bit master; the address counts 32-bit words.
	typedef struct packed {
		pi1_op_t                      op;
		logic [`PI1_NADDR_BITS-1:0]   addr;
		logic [`PI1_NARROW_BITS-1:0]  data;
		logic [`PI1_NSEL_BITS-1:0]    sel;
	} pi1_nreq_t;

	// Request on the 64-bit side.
	typedef struct packed {
		pi1_op_t                      op;
		logic [`PI1_WADDR_BITS-1:0]   addr;
		logic [`PI1_WIDE_BITS-1:0]    data;
		logic [`PI1_WSEL_BITS-1:0]    sel;
	} pi1_wreq_t;

endpackage

// File: source/pi1_config.svh
// pi1 memory subsystem sizes
`ifndef PI1_CONFIG_SVH
`define PI1_CONFIG_SVH

// Data width of the narrow master port.
`define PI1_NARROW_BITS 32

// Data width of the RAM and of the wide bus.
`define PI1_WIDE_BITS 64

`define PI1_WADDR_BITS 8 // Wide word address for 256 words.
`define PI1_NADDR_BITS (`PI1_WADDR_BITS + 1) // Narrow words are half as wide.

`define PI1_NSEL_BITS (`PI1_NARROW_BITS / 8)
`define PI1_WSEL_BITS (`PI1_WIDE_BITS / 8)

`define PI1_RAM_DEPTH (1 << `PI1_WADDR_BITS)

`endif

// File: source/pi1_sram.sv
// 64-bit pi1 RAM
`timescale 1ns/10ps
`include "pi1_config.svh"

module pi1_sram (
	input  logic                    clk_i,
	input  logic                    reset_i,

	input  pi1_bus_pkg::pi1_wreq_t  req_i,
	output mem_pkg::mem_word_t      data_o,
	output logic                    rdy_o
);

	mem_pkg::mem_word_t mem_q [`PI1_RAM_DEPTH];
	mem_pkg::mem_word_t data_q;

	mem_pkg::mem_index_t index;
	mem_pkg::mem_be_t    be;

	logic recover_q; // Write recovery cycle.
	logic accept;
	logic do_read;
	logic do_write;

	assign index = req_i.addr;
	assign be    = req_i.sel;

	assign rdy_o  = !recover_q;
	assign accept = rdy_o && (req_i.op != pi1_bus_pkg::PI1_OP_NOP);

	assign do_read = accept && (req_i.op == pi1_bus_pkg::PI1_OP_READ
		|| req_i.op == pi1_bus_pkg::PI1_OP_SWAP);
	assign do_write = accept && (req_i.op == pi1_bus_pkg::PI1_OP_WRITE
		|| req_i.op == pi1_bus_pkg::PI1_OP_SWAP);

	// A swap reads the old word here before the store below lands.
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			recover_q <= 1'b0;
			data_q    <= '0;
		end else begin
			recover_q <= do_write;
			if (do_read) begin
				data_q <= mem_q[index];
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (do_write) begin
			for (int i = 0; i < `PI1_WSEL_BITS; i++) begin
				if (be[i]) begin
					mem_q[index][i*8 +: 8] <= req_i.data[i*8 +: 8];
				end
			end
		end
	end

	assign data_o = data_q;

	// A recovery cycle neither stores nor loads, so the flag clears and the read word holds.
	a_write_recovery : assert property (
		@(posedge clk_i) disable iff (reset_i)
		recover_q |=> (!recover_q && $stable(data_o))
	);

endmodule

// File: source/pi1_subsystem_top.sv
// pi1 memory subsystem
`timescale 1ns/10ps
`include "pi1_config.svh"

module pi1_subsystem_top (
	input  logic                         clk_i,
	input  logic                         reset_i,

	input  pi1_bus_pkg::pi1_nreq_t       narrow_req_i,
	output logic [`PI1_NARROW_BITS-1:0]  narrow_data_o,
	output logic                         narrow_rdy_o,

	input  pi1_bus_pkg::pi1_wreq_t       wide_req_i,
	output mem_pkg::mem_word_t           wide_data_o,
	output logic                         wide_rdy_o
);

	pi1_bus_pkg::pi1_wreq_t up_req;   // Upconverter to arbiter port A.
	mem_pkg::mem_word_t     up_data;
	logic                   up_rdy;

	pi1_bus_pkg::pi1_wreq_t ram_req;
	mem_pkg::mem_word_t     ram_data;
	logic                   ram_rdy;

	pi1_upconverter pi1_upconverter_inst (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.m_req_i  (narrow_req_i),
		.m_data_o (narrow_data_o),
		.m_rdy_o  (narrow_rdy_o),
		.s_req_o  (up_req),
		.s_data_i (up_data),
		.s_rdy_i  (up_rdy)
	);

	pi1_arbiter pi1_arbiter_inst (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.a_req_i  (up_req),
		.a_data_o (up_data),
		.a_rdy_o  (up_rdy),
		.b_req_i  (wide_req_i),
		.b_data_o (wide_data_o),
		.b_rdy_o  (wide_rdy_o),
		.s_req_o  (ram_req),
		.s_data_i (ram_data),
		.s_rdy_i  (ram_rdy)
	);

	pi1_sram pi1_sram_inst (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.req_i   (ram_req),
		.data_o  (ram_data),
		.rdy_o   (ram_rdy)
	);

endmodule

// File: source/pi1_upconverter.sv
// pi1 32-to-64 bit upconverter
`timescale 1ns/10ps
`include "pi1_config.svh"

module pi1_upconverter (
	input  logic                         clk_i,
	input  logic                         reset_i,

	input  pi1_bus_pkg::pi1_nreq_t       m_req_i,
	output logic [`PI1_NARROW_BITS-1:0]  m_data_o,
	output logic                         m_rdy_o,

	output pi1_bus_pkg::pi1_wreq_t       s_req_o,
	input  mem_pkg::mem_word_t           s_data_i,
	input  logic                         s_rdy_i
);

	logic lane;   // Upper half of the wide word when set.
	logic lane_q;

	assign lane = m_req_i.addr[0];

	always_comb begin
		s_req_o.op   = m_req_i.op;
		s_req_o.addr = m_req_i.addr[`PI1_NADDR_BITS-1:1];
		s_req_o.data = mem_pkg::mem_word_t'(m_req_i.data) << (lane ? `PI1_NARROW_BITS : 0);
		s_req_o.sel  = mem_pkg::mem_be_t'(m_req_i.sel) << (lane ? `PI1_NSEL_BITS : 0);
	end

	// The lane is taken on every ready cycle, so it matches the last accepted request.
	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			lane_q <= 1'b0;
		end else if (s_rdy_i) begin
			lane_q <= lane;
		end
	end

	always_comb begin
		if (lane_q) begin
			m_data_o = s_data_i[`PI1_WIDE_BITS-1 -: `PI1_NARROW_BITS];
		end else begin
			m_data_o = s_data_i[`PI1_NARROW_BITS-1:0];
		end
	end

	assign m_rdy_o = s_rdy_i;

	// A store that reaches the wide side must touch at least one byte of its lane.
	a_store_has_sel : assert property (
		@(posedge clk_i) disable iff (reset_i)
		(s_rdy_i && (s_req_o.op == pi1_bus_pkg::PI1_OP_WRITE
			|| s_req_o.op == pi1_bus_pkg::PI1_OP_SWAP))
		|-> (|s_req_o.sel)
	);

endmodule

// File: tests/tb_pi1_subsystem.sv
// pi1 subsystem testbench
`timescale 1ns/10ps
`include "pi1_config.svh"

module tb_pi1_subsystem;

	localparam int NUM_TXNS       = 1500;
	localparam int TIMEOUT_CYCLES = NUM_TXNS * 6 + 100;
	localparam int WINDOW_WORDS   = 16; // Small window so that both ports hit the same words.

	logic clk_i = 1'b0;
	logic reset_i;

	pi1_bus_pkg::pi1_nreq_t       narrow_req;
	pi1_bus_pkg::pi1_wreq_t       wide_req;
	logic [`PI1_NARROW_BITS-1:0]  narrow_data;
	logic                         narrow_rdy;
	mem_pkg::mem_word_t           wide_data;
	logic                         wide_rdy;

	logic [31:0]        lfsr_q = 32'h4d79b691;
	mem_pkg::mem_word_t shadow [`PI1_RAM_DEPTH];
	int                 cycle_count = 0;
	logic               idle_check = 1'b0;

	logic                         n_want;
	logic                         w_want;
	logic                         n_acc;
	logic                         w_acc;
	logic                         n_ret_q;
	logic                         w_ret_q;
	logic                         store_q;       // The RAM is in write recovery.
	logic                         prio_narrow_q; // The narrow port wins the next contest.
	logic [`PI1_NARROW_BITS-1:0]  n_exp_q;
	mem_pkg::mem_word_t           w_exp_q;

	always #10 clk_i = ~clk_i;

	pi1_subsystem_top pi1_subsystem_top_inst (
		.clk_i         (clk_i),
		.reset_i       (reset_i),
		.narrow_req_i  (narrow_req),
		.narrow_data_o (narrow_data),
		.narrow_rdy_o  (narrow_rdy),
		.wide_req_i    (wide_req),
		.wide_data_o   (wide_data),
		.wide_rdy_o    (wide_rdy)
	);

	always @(posedge clk_i) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles.", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$fatal(1, "simulation timed out");
		end
	end

	task automatic report_mismatch(input string name, input logic [63:0] exp,
		input logic [63:0] act);
		$display("[ERROR] time %0t: %s expected %h, got %h", $time, name, exp, act);
		$display("=== FAIL ===");
		$fatal(1, "value mismatch");
	endtask

	task automatic report_failure(input string what);
		$display("Check failed at time %0t: %s.", $time, what);
		$display("=== FAIL ===");
		$fatal(1, "check failed");
	endtask

	// Taps 32, 22, 2 and 1; one step per bit handed out.
	function automatic logic [63:0] rand_bits(input int n);
		logic [63:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			r      = {r[62:0], fb};
		end
		return r;
	endfunction

	function automatic logic is_load(input pi1_bus_pkg::pi1_op_t op);
		return op == pi1_bus_pkg::PI1_OP_READ || op == pi1_bus_pkg::PI1_OP_SWAP;
	endfunction

	function automatic logic is_store(input pi1_bus_pkg::pi1_op_t op);
		return op == pi1_bus_pkg::PI1_OP_WRITE || op == pi1_bus_pkg::PI1_OP_SWAP;
	endfunction

	function automatic pi1_bus_pkg::pi1_nreq_t random_narrow();
		pi1_bus_pkg::pi1_nreq_t r;
		r.op   = pi1_bus_pkg::pi1_op_t'(2'(rand_bits(2)));
		r.addr = 9'(rand_bits(5));
		r.data = 32'(rand_bits(32));
		r.sel  = 4'(rand_bits(4));
		if (is_store(r.op) && r.sel == '0) begin
			r.sel = 4'b0001;
		end
		return r;
	endfunction

	function automatic pi1_bus_pkg::pi1_wreq_t random_wide();
		pi1_bus_pkg::pi1_wreq_t r;
		r.op   = pi1_bus_pkg::pi1_op_t'(2'(rand_bits(2)));
		r.addr = 8'(rand_bits(4));
		r.data = rand_bits(64);
		r.sel  = 8'(rand_bits(8));
		return r;
	endfunction

	task automatic store_bytes(input mem_pkg::mem_index_t idx, input mem_pkg::mem_word_t data,
		input mem_pkg::mem_be_t be);
		for (int i = 0; i < `PI1_WSEL_BITS; i++) begin
			if (be[i]) begin
				shadow[idx][i*8 +: 8] = data[i*8 +: 8];
			end
		end
	endtask

	// Address bit 0 names the 32-bit half of the wide word.
	task automatic apply_narrow(input pi1_bus_pkg::pi1_nreq_t r);
		mem_pkg::mem_index_t idx;
		mem_pkg::mem_word_t  word;
		idx  = r.addr[`PI1_NADDR_BITS-1:1];
		word = shadow[idx];
		if (is_load(r.op)) begin
			n_exp_q <= r.addr[0] ? word[63:32] : word[31:0];
		end
		if (is_store(r.op)) begin
			if (r.addr[0]) begin
				store_bytes(idx, {r.data, 32'h0}, {r.sel, 4'h0});
			end else begin
				store_bytes(idx, {32'h0, r.data}, {4'h0, r.sel});
			end
		end
	endtask

	task automatic apply_wide(input pi1_bus_pkg::pi1_wreq_t r);
		if (is_load(r.op)) begin
			w_exp_q <= shadow[r.addr];
		end
		if (is_store(r.op)) begin
			store_bytes(r.addr, r.data, r.sel);
		end
	endtask

	assign n_want = (narrow_req.op != pi1_bus_pkg::PI1_OP_NOP);
	assign w_want = (wide_req.op != pi1_bus_pkg::PI1_OP_NOP);
	assign n_acc  = n_want && narrow_rdy;
	assign w_acc  = w_want && wide_rdy;

	always @(posedge clk_i) begin
		if (reset_i) begin
			n_ret_q       <= 1'b0;
			w_ret_q       <= 1'b0;
			store_q       <= 1'b0;
			prio_narrow_q <= 1'b1;
		end else begin
			n_ret_q <= n_acc && is_load(narrow_req.op);
			w_ret_q <= w_acc && is_load(wide_req.op);
			store_q <= (n_acc && is_store(narrow_req.op)) || (w_acc && is_store(wide_req.op));
			if (n_want && w_want && (n_acc || w_acc)) begin
				prio_narrow_q <= w_acc; // The loser of a contest wins the next one.
			end
			if (n_acc) begin
				apply_narrow(narrow_req);
			end
			if (w_acc) begin
				apply_wide(wide_req);
			end
		end
	end

	a_reset_rdy : assert property (@(posedge clk_i) disable iff (reset_i)
		idle_check |-> (narrow_rdy && wide_rdy))
		else report_failure("a rdy output was low right after reset");
	a_reset_ndata : assert property (@(posedge clk_i) disable iff (reset_i)
		idle_check |-> (narrow_data == '0))
		else report_mismatch("narrow_data_o", 64'h0, 64'($sampled(narrow_data)));
	a_reset_wdata : assert property (@(posedge clk_i) disable iff (reset_i)
		idle_check |-> (wide_data == '0))
		else report_mismatch("wide_data_o", 64'h0, $sampled(wide_data));
	a_narrow_read : assert property (@(posedge clk_i) disable iff (reset_i)
		n_ret_q |-> (narrow_data == n_exp_q))
		else report_mismatch("narrow_data_o", 64'($sampled(n_exp_q)),
			64'($sampled(narrow_data)));
	a_wide_read : assert property (@(posedge clk_i) disable iff (reset_i)
		w_ret_q |-> (wide_data == w_exp_q))
		else report_mismatch("wide_data_o", $sampled(w_exp_q), $sampled(wide_data));
	a_store_stall : assert property (@(posedge clk_i) disable iff (reset_i)
		store_q |-> (!narrow_rdy && !wide_rdy))
		else report_failure("a rdy output was high in the cycle after a store");
	a_one_winner : assert property (@(posedge clk_i) disable iff (reset_i)
		(n_want && w_want && !store_q) |-> (narrow_rdy != wide_rdy))
		else report_failure("a contested cycle did not accept exactly one port");
	a_alternate : assert property (@(posedge clk_i) disable iff (reset_i)
		(n_want && w_want && !store_q) |-> (narrow_rdy == prio_narrow_q))
		else report_failure("contested acceptances did not alternate between the ports");

	task automatic preload_word(input mem_pkg::mem_index_t idx);
		pi1_bus_pkg::pi1_wreq_t r;
		r.op     = pi1_bus_pkg::PI1_OP_WRITE;
		r.addr   = idx;
		r.data   = rand_bits(64);
		r.sel    = '1;
		wide_req <= r;
		@(posedge clk_i);
		while (!wide_rdy) begin
			@(posedge clk_i);
		end
	endtask

	initial begin
		pi1_bus_pkg::pi1_nreq_t next_n;
		pi1_bus_pkg::pi1_wreq_t next_w;
		int                     issued;
		reset_i    = 1'b1;
		narrow_req = '0;
		wide_req   = '0;
		issued     = 0;
		repeat (5) @(posedge clk_i);
		reset_i    <= 1'b0;
		idle_check <= 1'b1;
		@(posedge clk_i);
		idle_check <= 1'b0;
		for (int i = 0; i < WINDOW_WORDS; i++) begin
			preload_word(mem_pkg::mem_index_t'(i)); // Every word in the window gets a known value.
		end
		while (issued < NUM_TXNS || n_want || w_want) begin
			if (!n_want || narrow_rdy) begin
				next_n = '0;
				if (issued < NUM_TXNS) begin
					next_n = random_narrow();
					issued += (next_n.op != pi1_bus_pkg::PI1_OP_NOP) ? 1 : 0;
				end
				narrow_req <= next_n;
			end
			if (!w_want || wide_rdy) begin
				next_w = '0;
				if (issued < NUM_TXNS) begin
					next_w = random_wide();
					issued += (next_w.op != pi1_bus_pkg::PI1_OP_NOP) ? 1 : 0;
				end
				wide_req <= next_w;
			end
			@(posedge clk_i);
		end
		repeat (3) @(posedge clk_i); // Lets the last read data reach its check.
		$display("=== PASS ===");
		$finish;
	end

endmodule
